//--- list.f
+incdir+logic
logic/mem_map_pkg.sv
logic/addr_decoder.sv
logic/dual_port_ram.sv
logic/io_return_path.sv
logic/memory_map.sv
tests/clk_gen.sv
tests/memory_map_chk.sv
tests/tb_memory_map.sv

//--- logic/addr_decoder.sv
// purely combinational decode, so the request is valid in the same cycle as the address
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module addr_decoder
  import mem_map_pkg::*;
(
  input  logic [`MM_ADDR_WIDTH-1:0] addr,
  input  logic [`MM_DATA_WIDTH-1:0] wdata,
  input  logic                      write,
  output mm_req_t                   req
);

  region_e    region;
  access_op_e op;

  //////////////////////////////////////////////////////////////////////
  // region select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (addr < `MM_RAM_DEPTH) begin
      region = REGION_RAM;  // plain RAM word
    end else if (addr == `MM_IO_IN_ADDR) begin
      region = REGION_IO_IN;
    end else if (addr == `MM_IO_OUT_ADDR) begin
      region = REGION_IO_OUT;
    end else begin
      region = REGION_NONE;  // 512 and above
    end
  end

  // write level to op code
  always_comb begin
    if (write) begin
      op = OP_WRITE;
    end else begin
      op = OP_READ;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // request struct
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    req.region    = region;
    req.op        = op;
    req.ram_index = addr[`MM_RAM_INDEX_WIDTH-1:0];  // only meaningful in RAM region
    req.wdata     = wdata;
  end

endmodule

//--- logic/dual_port_ram.sv
// no reset on contents or read registers; read data is undefined until a word is written
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module dual_port_ram
  import mem_map_pkg::*;
(
  input  logic                      clk,
  input  mm_req_t                   req_a,
  input  mm_req_t                   req_b,
  output logic [`MM_DATA_WIDTH-1:0] ram_q_a,
  output logic [`MM_DATA_WIDTH-1:0] ram_q_b
);

  logic [`MM_DATA_WIDTH-1:0] mem [`MM_RAM_DEPTH];

  logic re_a;
  logic re_b;
  logic we_a;
  logic we_b;
  logic same_index;

  //////////////////////////////////////////////////////////////////////
  // port enables
  //////////////////////////////////////////////////////////////////////

  // only RAM-region requests touch the array
  assign re_a = (req_a.region == REGION_RAM);
  assign re_b = (req_b.region == REGION_RAM);

  assign same_index = (req_a.ram_index == req_b.ram_index);

  assign we_a = re_a && (req_a.op == OP_WRITE);

  // port A wins a write collision
  assign we_b = re_b && (req_b.op == OP_WRITE) && !(we_a && same_index);

  //////////////////////////////////////////////////////////////////////
  // array writes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we_a) begin
      mem[req_a.ram_index] <= req_a.wdata;
    end
    if (we_b) begin
      mem[req_b.ram_index] <= req_b.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // registered reads
  //////////////////////////////////////////////////////////////////////

  // nonblocking reads see the array before this edge's writes
  always_ff @(posedge clk) begin
    if (re_a) begin
      ram_q_a <= mem[req_a.ram_index];  // read-first
    end
  end

  always_ff @(posedge clk) begin
    if (re_b) begin
      ram_q_b <= mem[req_b.ram_index];  // read-first
    end
  end

endmodule

//--- logic/io_return_path.sv
// one output register only; reads of the I/O words see the value before the same edge's write
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module io_return_path
  import mem_map_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  mm_req_t                   req_a,
  input  mm_req_t                   req_b,
  input  logic [`MM_DATA_WIDTH-1:0] ram_q_a,
  input  logic [`MM_DATA_WIDTH-1:0] ram_q_b,
  input  logic [`MM_DATA_WIDTH-1:0] input_data,
  output logic [`MM_DATA_WIDTH-1:0] read_data_a,
  output logic [`MM_DATA_WIDTH-1:0] read_data_b,
  output logic [`MM_DATA_WIDTH-1:0] io_output_data
);

  region_e                   region_q_a;
  region_e                   region_q_b;
  logic [`MM_DATA_WIDTH-1:0] in_q;
  logic [`MM_DATA_WIDTH-1:0] out_snap;
  logic                      wr_out_a;
  logic                      wr_out_b;

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  assign wr_out_a = (req_a.region == REGION_IO_OUT) && (req_a.op == OP_WRITE);
  assign wr_out_b = (req_b.region == REGION_IO_OUT) && (req_b.op == OP_WRITE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      io_output_data <= '0;
    end else if (wr_out_a) begin
      io_output_data <= req_a.wdata;  // A has priority
    end else if (wr_out_b) begin
      io_output_data <= req_b.wdata;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read-side registers
  //////////////////////////////////////////////////////////////////////

  // region of each read, NONE in reset keeps read data at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      region_q_a <= REGION_NONE;
      region_q_b <= REGION_NONE;
    end else begin
      region_q_a <= req_a.region;
      region_q_b <= req_b.region;
    end
  end

  // shared by both ports, both read the same edge
  always_ff @(posedge clk) begin
    in_q     <= input_data;      // input word at the read edge
    out_snap <= io_output_data;  // old value, before this edge's write
  end

  //////////////////////////////////////////////////////////////////////
  // read data select
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`MM_DATA_WIDTH-1:0] pick_read(
    input region_e                   region,
    input logic [`MM_DATA_WIDTH-1:0] ram_q,
    input logic [`MM_DATA_WIDTH-1:0] in_word,
    input logic [`MM_DATA_WIDTH-1:0] out_word
  );
    logic [`MM_DATA_WIDTH-1:0] result;
    case (region)
      REGION_RAM:    result = ram_q;
      REGION_IO_IN:  result = in_word;
      REGION_IO_OUT: result = out_word;
      default:       result = '0;  // unmapped
    endcase
    return result;
  endfunction

  assign read_data_a = pick_read(region_q_a, ram_q_a, in_q, out_snap);
  assign read_data_b = pick_read(region_q_b, ram_q_b, in_q, out_snap);

endmodule

//--- logic/mem_map_defines.svh
// RAM depth must stay below both I/O addresses and fit in the 9 bit RAM index
`ifndef MEM_MAP_DEFINES_SVH
`define MEM_MAP_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// word and address widths
//////////////////////////////////////////////////////////////////////

`define MM_DATA_WIDTH 16       // one data word
`define MM_ADDR_WIDTH 16       // full port address

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

`define MM_RAM_DEPTH 510       // RAM words at 0..509
`define MM_RAM_INDEX_WIDTH 9   // enough bits for 0..509

`define MM_IO_IN_ADDR 510      // read-only input word
`define MM_IO_OUT_ADDR 511     // output register

// anything from 512 up is unmapped, reads give zero

`endif

//--- logic/mem_map_pkg.sv
// request types for both ports; region encoding is fixed at 2 bits and the RAM index at 9
`include "mem_map_defines.svh"

package mem_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // decode results
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    REGION_RAM    = 2'd0,  // 0..509
    REGION_IO_IN  = 2'd1,  // input word
    REGION_IO_OUT = 2'd2,  // output register
    REGION_NONE   = 2'd3   // unmapped
  } region_e;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } access_op_e;

  // one port's request for one cycle
  typedef struct packed {
    region_e                          region;
    access_op_e                       op;
    logic [`MM_RAM_INDEX_WIDTH-1:0]   ram_index;  // low address bits
    logic [`MM_DATA_WIDTH-1:0]        wdata;
  } mm_req_t;

endpackage

//--- logic/memory_map.sv
// no handshake or back-pressure; every port accepts one request per cycle with fixed 1 cycle read latency
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module memory_map
  import mem_map_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`MM_ADDR_WIDTH-1:0] addr_a,
  input  logic [`MM_DATA_WIDTH-1:0] data_a,
  input  logic                      write_a,
  input  logic [`MM_ADDR_WIDTH-1:0] addr_b,
  input  logic [`MM_DATA_WIDTH-1:0] data_b,
  input  logic                      write_b,
  input  logic [`MM_DATA_WIDTH-1:0] input_data,
  output logic [`MM_DATA_WIDTH-1:0] read_data_a,
  output logic [`MM_DATA_WIDTH-1:0] read_data_b,
  output logic [`MM_DATA_WIDTH-1:0] io_output_data
);

  mm_req_t                   req_a;
  mm_req_t                   req_b;
  logic [`MM_DATA_WIDTH-1:0] ram_q_a;
  logic [`MM_DATA_WIDTH-1:0] ram_q_b;

  //////////////////////////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////////////////////////

  addr_decoder u_dec_a (
    .addr  (addr_a),
    .wdata (data_a),
    .write (write_a),
    .req   (req_a)
  );

  addr_decoder u_dec_b (
    .addr  (addr_b),
    .wdata (data_b),
    .write (write_b),
    .req   (req_b)
  );

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  dual_port_ram u_ram (
    .clk     (clk),
    .req_a   (req_a),
    .req_b   (req_b),
    .ram_q_a (ram_q_a),
    .ram_q_b (ram_q_b)
  );

  //////////////////////////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////////////////////////

  io_return_path u_return (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_a          (req_a),
    .req_b          (req_b),
    .ram_q_a        (ram_q_a),
    .ram_q_b        (ram_q_b),
    .input_data     (input_data),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b),
    .io_output_data (io_output_data)
  );

endmodule

//--- tests/clk_gen.sv
// 20 ns clock from time zero; rst_n starts high for 1 ns so its fall is a real edge, then low for 3 cycles
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 10;  // 20 ns period

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst_n = 1'b1;
    #1 rst_n = 1'b0;            // clean falling edge
    repeat (3) @(posedge clk);  // held over three rising edges
    #1 rst_n = 1'b1;
  end

endmodule

//--- tests/memory_map_chk.sv
// shadow model of the map; a RAM word is checked only once it has been written since reset
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module memory_map_chk (
  input logic                      clk,
  input logic                      rst_n,
  input logic [`MM_ADDR_WIDTH-1:0] addr_a,
  input logic [`MM_DATA_WIDTH-1:0] data_a,
  input logic                      write_a,
  input logic [`MM_ADDR_WIDTH-1:0] addr_b,
  input logic [`MM_DATA_WIDTH-1:0] data_b,
  input logic                      write_b,
  input logic [`MM_DATA_WIDTH-1:0] input_data,
  input logic [`MM_DATA_WIDTH-1:0] read_data_a,
  input logic [`MM_DATA_WIDTH-1:0] read_data_b,
  input logic [`MM_DATA_WIDTH-1:0] io_output_data
);

  logic [`MM_DATA_WIDTH-1:0] shadow_ram [`MM_RAM_DEPTH];
  logic [`MM_RAM_DEPTH-1:0]  ram_known;   // word written since reset
  logic [`MM_DATA_WIDTH-1:0] shadow_out;
  logic [`MM_DATA_WIDTH-1:0] exp_a;       // expected read data, one cycle on
  logic [`MM_DATA_WIDTH-1:0] exp_b;
  logic                      chk_a;
  logic                      chk_b;

  int unsigned               fail_count = 0;
  string                     last_sig = "none";
  logic [`MM_DATA_WIDTH-1:0] last_got = '0;
  logic [`MM_DATA_WIDTH-1:0] last_exp = '0;

  //////////////////////////////////////////////////////////////////////
  // shadow model
  //////////////////////////////////////////////////////////////////////

  // value a read returns, taken before this edge's writes
  function automatic logic [`MM_DATA_WIDTH-1:0] predict_value(
    input logic [`MM_ADDR_WIDTH-1:0] addr
  );
    logic [`MM_DATA_WIDTH-1:0] value;
    if (addr < `MM_RAM_DEPTH) begin
      value = shadow_ram[addr[`MM_RAM_INDEX_WIDTH-1:0]];
    end else if (addr == `MM_IO_IN_ADDR) begin
      value = input_data;  // word present at the read edge
    end else if (addr == `MM_IO_OUT_ADDR) begin
      value = shadow_out;
    end else begin
      value = '0;  // unmapped
    end
    return value;
  endfunction

  function automatic logic predict_known(input logic [`MM_ADDR_WIDTH-1:0] addr);
    logic known;
    if (addr < `MM_RAM_DEPTH) begin
      known = ram_known[addr[`MM_RAM_INDEX_WIDTH-1:0]];
    end else begin
      known = 1'b1;
    end
    return known;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_known  <= '0;
      shadow_out <= '0;
      exp_a      <= '0;
      exp_b      <= '0;
      chk_a      <= 1'b0;
      chk_b      <= 1'b0;
    end else begin
      exp_a <= predict_value(addr_a);
      exp_b <= predict_value(addr_b);
      chk_a <= predict_known(addr_a);
      chk_b <= predict_known(addr_b);
      // B goes first so a colliding A write lands last
      if (write_b && addr_b < `MM_RAM_DEPTH) begin
        shadow_ram[addr_b[`MM_RAM_INDEX_WIDTH-1:0]] <= data_b;
        ram_known[addr_b[`MM_RAM_INDEX_WIDTH-1:0]]  <= 1'b1;
      end
      if (write_a && addr_a < `MM_RAM_DEPTH) begin
        shadow_ram[addr_a[`MM_RAM_INDEX_WIDTH-1:0]] <= data_a;
        ram_known[addr_a[`MM_RAM_INDEX_WIDTH-1:0]]  <= 1'b1;
      end
      if (write_a && addr_a == `MM_IO_OUT_ADDR) begin
        shadow_out <= data_a;  // A has priority
      end else if (write_b && addr_b == `MM_IO_OUT_ADDR) begin
        shadow_out <= data_b;
      end
    end
  end

  task automatic note_mismatch(
    input string                     sig,
    input logic [`MM_DATA_WIDTH-1:0] got,
    input logic [`MM_DATA_WIDTH-1:0] exp
  );
    fail_count++;
    last_sig = sig;
    last_got = got;
    last_exp = exp;
  endtask

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  property zero_around_reset(sig);
    @(posedge clk) (!rst_n || $rose(rst_n)) |-> (sig === '0);
  endproperty

  a_rst_rd_a: assert property (zero_around_reset(read_data_a))
    else begin
      note_mismatch("read_data_a", $sampled(read_data_a), '0);
      $error("read_data_a = 0x%h around reset, expected 0", $sampled(read_data_a));
    end

  a_rst_rd_b: assert property (zero_around_reset(read_data_b))
    else begin
      note_mismatch("read_data_b", $sampled(read_data_b), '0);
      $error("read_data_b = 0x%h around reset, expected 0", $sampled(read_data_b));
    end

  a_rst_out: assert property (zero_around_reset(io_output_data))
    else begin
      note_mismatch("io_output_data", $sampled(io_output_data), '0);
      $error("io_output_data = 0x%h around reset, expected 0", $sampled(io_output_data));
    end

  a_read_a: assert property (@(posedge clk) disable iff (!rst_n)
      chk_a |-> (read_data_a === exp_a))
    else begin
      note_mismatch("read_data_a", $sampled(read_data_a), $sampled(exp_a));
      $error("read_data_a = 0x%h, expected 0x%h", $sampled(read_data_a), $sampled(exp_a));
    end

  a_read_b: assert property (@(posedge clk) disable iff (!rst_n)
      chk_b |-> (read_data_b === exp_b))
    else begin
      note_mismatch("read_data_b", $sampled(read_data_b), $sampled(exp_b));
      $error("read_data_b = 0x%h, expected 0x%h", $sampled(read_data_b), $sampled(exp_b));
    end

  a_out_reg: assert property (@(posedge clk) disable iff (!rst_n)
      io_output_data === shadow_out)
    else begin
      note_mismatch("io_output_data", $sampled(io_output_data), $sampled(shadow_out));
      $error("io_output_data = 0x%h, expected 0x%h",
             $sampled(io_output_data), $sampled(shadow_out));
    end

endmodule

bind memory_map memory_map_chk u_chk (.*);

//--- tests/tb_memory_map.sv
// directed and random traffic on both ports; the bound shadow-model assertions do the checking
`timescale 1ns/1ps
`include "mem_map_defines.svh"

module tb_memory_map;

  localparam int DRIVE_DELAY     = 2;    // ns after the rising edge
  localparam int DIRECTED_CYCLES = 200;  // bound for the five directed tests
  localparam int RANDOM_CYCLES   = 200;
  localparam int WATCHDOG_CYCLES = 2 * (DIRECTED_CYCLES + RANDOM_CYCLES);

  localparam logic [`MM_ADDR_WIDTH-1:0] IDLE_ADDR = 16'hffff;  // unmapped so it reads zero
  localparam logic [`MM_ADDR_WIDTH-1:0] IN_ADDR   = `MM_IO_IN_ADDR;
  localparam logic [`MM_ADDR_WIDTH-1:0] OUT_ADDR  = `MM_IO_OUT_ADDR;

  logic                      clk;
  logic                      rst_n;
  logic [`MM_ADDR_WIDTH-1:0] addr_a;
  logic [`MM_DATA_WIDTH-1:0] data_a;
  logic                      write_a;
  logic [`MM_ADDR_WIDTH-1:0] addr_b;
  logic [`MM_DATA_WIDTH-1:0] data_b;
  logic                      write_b;
  logic [`MM_DATA_WIDTH-1:0] input_data;
  logic [`MM_DATA_WIDTH-1:0] read_data_a;
  logic [`MM_DATA_WIDTH-1:0] read_data_b;
  logic [`MM_DATA_WIDTH-1:0] io_output_data;

  int          tests_run;
  int          tests_failed;
  int unsigned fails_at_start;

  clk_gen u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  memory_map u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr_a         (addr_a),
    .data_a         (data_a),
    .write_a        (write_a),
    .addr_b         (addr_b),
    .data_b         (data_b),
    .write_b        (write_b),
    .input_data     (input_data),
    .read_data_a    (read_data_a),
    .read_data_b    (read_data_b),
    .io_output_data (io_output_data)
  );

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // pins held through exactly one rising edge
  task automatic run_cycle(
    input logic [`MM_ADDR_WIDTH-1:0] a_addr,
    input logic [`MM_DATA_WIDTH-1:0] a_data,
    input logic                      a_wr,
    input logic [`MM_ADDR_WIDTH-1:0] b_addr,
    input logic [`MM_DATA_WIDTH-1:0] b_data,
    input logic                      b_wr
  );
    addr_a  = a_addr;
    data_a  = a_data;
    write_a = a_wr;
    addr_b  = b_addr;
    data_b  = b_data;
    write_b = b_wr;
    next_cycle();
  endtask

  function automatic logic [`MM_DATA_WIDTH-1:0] rand_word();
    logic [31:0] r;
    r = $urandom;
    return r[`MM_DATA_WIDTH-1:0];
  endfunction

  function automatic logic [`MM_ADDR_WIDTH-1:0] random_addr();
    logic [`MM_ADDR_WIDTH-1:0] addr;
    case ($urandom_range(3, 0))
      0:       addr = 16'($urandom_range(63, 0));  // small window so reads hit known words
      1:       addr = IN_ADDR;
      2:       addr = OUT_ADDR;
      default: addr = 16'($urandom_range(16'hffff, 512));
    endcase
    return addr;
  endfunction

  task automatic start_test();
    fails_at_start = u_dut.u_chk.fail_count;
  endtask

  // two idle cycles let the last reads reach their check
  task automatic finish_test(input string name);
    int unsigned new_fails;
    run_cycle(IDLE_ADDR, '0, 1'b0, IDLE_ADDR, '0, 1'b0);
    run_cycle(IDLE_ADDR, '0, 1'b0, IDLE_ADDR, '0, 1'b0);
    new_fails = u_dut.u_chk.fail_count - fails_at_start;
    tests_run++;
    if (new_fails == 0) begin
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s: %s = 0x%h, expected 0x%h (%0d assertion failures)", name,
               u_dut.u_chk.last_sig, u_dut.u_chk.last_got, u_dut.u_chk.last_exp, new_fails);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_ram_ports();
    start_test();
    for (int i = 0; i < 16; i++) begin
      run_cycle(16'(i), rand_word(), 1'b1, 16'(16 + i), rand_word(), 1'b1);
    end
    for (int i = 0; i < 16; i++) begin
      run_cycle(16'(16 + i), '0, 1'b0, 16'(i), '0, 1'b0);  // cross read-back
    end
    run_cycle(16'd5, rand_word(), 1'b1, 16'd5, '0, 1'b0);  // B sees old word 5
    run_cycle(IDLE_ADDR, '0, 1'b0, 16'd5, '0, 1'b0);
    run_cycle(16'd20, '0, 1'b0, 16'd20, rand_word(), 1'b1);
    run_cycle(16'd20, '0, 1'b0, IDLE_ADDR, '0, 1'b0);
    finish_test("ram_ports");
  endtask

  task automatic test_collision();
    logic [`MM_DATA_WIDTH-1:0] word;
    start_test();
    word = rand_word();
    run_cycle(16'd40, word, 1'b1, 16'd40, ~word, 1'b1);
    run_cycle(16'd40, '0, 1'b0, 16'd40, '0, 1'b0);
    word = rand_word();
    run_cycle(OUT_ADDR, word, 1'b1, OUT_ADDR, ~word, 1'b1);
    run_cycle(OUT_ADDR, '0, 1'b0, OUT_ADDR, '0, 1'b0);
    finish_test("collision");
  endtask

  task automatic test_io_input();
    start_test();
    for (int i = 0; i < 12; i++) begin
      input_data = rand_word();  // new word every cycle
      run_cycle(IN_ADDR, '0, 1'b0, IN_ADDR, '0, 1'b0);
    end
    input_data = rand_word();
    run_cycle(IN_ADDR, rand_word(), 1'b1, IN_ADDR, rand_word(), 1'b1);
    run_cycle(IN_ADDR, '0, 1'b0, OUT_ADDR, '0, 1'b0);
    finish_test("io_input");
  endtask

  task automatic test_io_output_unmapped();
    start_test();
    for (int i = 0; i < 4; i++) begin
      run_cycle(OUT_ADDR, rand_word(), 1'b1, IDLE_ADDR, '0, 1'b0);
      run_cycle(IDLE_ADDR, '0, 1'b0, OUT_ADDR, '0, 1'b0);
    end
    run_cycle(16'd512, '0, 1'b0, 16'h8000, '0, 1'b0);
    // low bits alias RAM words 0 and 1
    run_cycle(16'd512, rand_word(), 1'b1, 16'd513, rand_word(), 1'b1);
    run_cycle(16'hfffe, rand_word(), 1'b1, 16'h8000, rand_word(), 1'b1);
    run_cycle(16'd0, '0, 1'b0, 16'd1, '0, 1'b0);
    run_cycle(OUT_ADDR, '0, 1'b0, IDLE_ADDR, '0, 1'b0);
    finish_test("io_output_unmapped");
  endtask

  task automatic test_random_mix();
    start_test();
    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      input_data = rand_word();
      run_cycle(random_addr(), rand_word(), 1'($urandom_range(1, 0)),
                random_addr(), rand_word(), 1'($urandom_range(1, 0)));
    end
    finish_test("random_mix");
  endtask

  //////////////////////////////////////////////////////////////////////
  // sequencing and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    addr_a         = IDLE_ADDR;
    data_a         = '0;
    write_a        = 1'b0;
    addr_b         = IDLE_ADDR;
    data_b         = '0;
    write_b        = 1'b0;
    input_data     = '0;
    tests_run      = 0;
    tests_failed   = 0;
    fails_at_start = 0;
    void'($urandom(97556));
    start_test();
    wait (rst_n === 1'b0);  // reset pulse starts just after time zero
    wait (rst_n === 1'b1);
    next_cycle();
    finish_test("reset");
    test_ram_ports();
    test_collision();
    test_io_input();
    test_io_output_unmapped();
    test_random_mix();
    $display("summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
             tests_run, tests_run - tests_failed, tests_failed, u_dut.u_chk.fail_count);
    if (tests_failed == 0 && u_dut.u_chk.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
